//--- memory_game.f
game_pkg.sv
display_pkg.sv
board_state.sv
turn_control.sv
score_keeper.sv
turn_timer.sv
score_display.sv
memory_game.sv
tb_memory_game.sv

//--- run.sh
#!/bin/sh
# build and run the memory game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_memory_game -f memory_game.f -o tb_memory_game
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_memory_game > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
echo "pass message missing from sim.log"
exit 1

//--- tb_memory_game.sv
// memory game testbench: directed turns, back-pressure stall, turn timeout and game over
`timescale 1ns/1ps

module tb_memory_game;
	import game_pkg::*;
	import display_pkg::*;

	localparam int TICKS_PER_SECOND = 4;
	localparam int TURN_SECONDS = 3;
	localparam int WAIT_LIMIT = 20;	// cycles a pick or result may take
	localparam int CYCLE_LIMIT = 3000;	// tests run near 150 cycles, wide margin
	// active-low patterns 0..9, segments g..a
	localparam logic [6:0] SEG_REF [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h18};
	localparam logic [6:0] SEG_OFF = 7'h7f;	// dark digit
	// the nine pairs, card and partner
	localparam card_idx_t PAIR_A [9] = '{5'd17, 5'd16, 5'd15, 5'd14, 5'd13, 5'd12, 5'd9, 5'd8, 5'd6};
	localparam card_idx_t PAIR_B [9] = '{5'd10, 5'd0, 5'd4, 5'd3, 5'd2, 5'd11, 5'd7, 5'd5, 5'd1};

	logic clock;
	logic reset_n;
	card_pick_t pick;
	logic pick_valid;
	logic pick_ready;
	turn_result_t result;
	logic result_valid;
	logic result_ready;
	player_t player;
	logic game_over;
	seg_digits_t digits;

	int mismatches;
	int failures;	// timeouts and other non-value errors
	int cycle_count = 0;
	logic [31:0] lfsr_state;
	int score0;	// expected scores
	int score1;
	logic cur_player;	// expected player on turn
	logic [8:0] cleared;	// pairs already taken, by table row

	memory_game #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.TURN_SECONDS(TURN_SECONDS)
	) i_dut (
		.clock, .reset_n, .pick, .pick_valid, .pick_ready,
		.result, .result_valid, .result_ready,
		.player, .game_over, .digits
	);

	always #50 clock = ~clock;	// 100 ns period

	// watchdog
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		repeat (count)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [6:0] seg_of(input int d);
		if (d < 0 || d > 9)
			return SEG_OFF;
		return SEG_REF[d[3:0]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			mismatches++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_scores(input int p0, input int p1);
		check_value("digits.score_p0", 32'(digits.score_p0), 32'(seg_of(p0)));
		check_value("digits.score_p1", 32'(digits.score_p1), 32'(seg_of(p1)));
	endtask

	// countdown just reloaded
	task automatic check_timer_full();
		check_value("digits.timer_tens", 32'(digits.timer_tens),
			32'((TURN_SECONDS / 10 == 0) ? SEG_OFF : seg_of(TURN_SECONDS / 10)));	// leading zero dark
		check_value("digits.timer_units", 32'(digits.timer_units), 32'(seg_of(TURN_SECONDS % 10)));
	endtask

	task automatic check_turn_result(input turn_result_t r, input logic p, input card_idx_t a,
		input card_idx_t b, input logic m, input logic t);
		check_value("result.player", 32'(r.player), 32'(p));
		check_value("result.card_a", 32'(r.card_a), 32'(a));
		check_value("result.card_b", 32'(r.card_b), 32'(b));
		check_value("result.matched", 32'(r.matched), 32'(m));
		check_value("result.timed_out", 32'(r.timed_out), 32'(t));
	endtask

	// holds valid until the handshake edge, returns on that edge
	task automatic send_pick(input card_idx_t card);
		int waited;
		logic taken;
		@(posedge clock);
		pick.card <= card;
		pick_valid <= 1'b1;
		waited = 0;
		taken = 1'b0;
		while (!taken && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			taken = pick_ready;	// sampled mid-cycle
			@(posedge clock);
			waited++;
		end
		pick_valid <= 1'b0;
		if (!taken)
		begin
			failures++;
			$display("pick of card %0d not accepted within %0d cycles", card, WAIT_LIMIT);
		end
	endtask

	task automatic wait_valid(input int limit, output turn_result_t r, output int waited);
		waited = 0;
		r = '0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (!result_valid && waited < limit);
		if (result_valid)
			r = result;
		else
		begin
			failures++;
			$display("no turn result within %0d cycles at %0t", limit, $time);
		end
	endtask

	// result_ready high, returns mid-cycle after the handshake
	task automatic take_result(output turn_result_t r);
		int waited;
		wait_valid(WAIT_LIMIT, r, waited);
		@(posedge clock);	// handshake edge
		@(negedge clock);
	endtask

	task automatic expect_no_result(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			check_value("result_valid", 32'(result_valid), 32'd0);
		end
	endtask

	task automatic test_reset();
		@(negedge clock);
		check_value("pick_ready", 32'(pick_ready), 32'd1);
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("game_over", 32'(game_over), 32'd0);
		check_value("player", 32'(player), 32'd0);
		check_scores(0, 0);
		check_timer_full();
	endtask

	task automatic test_match();
		turn_result_t r;
		send_pick(5'd17);
		send_pick(5'd10);
		take_result(r);
		check_turn_result(r, 1'b0, 5'd17, 5'd10, 1'b1, 1'b0);
		score0++;	// scorer keeps the turn
		cleared[0] = 1'b1;
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
		check_timer_full();
		send_pick(5'd17);	// removed card, dropped
		send_pick(5'd10);	// its partner, dropped too
		expect_no_result(2);
	endtask

	task automatic test_miss();
		turn_result_t r;
		send_pick(5'd16);
		send_pick(5'd1);
		take_result(r);
		check_turn_result(r, 1'b0, 5'd16, 5'd1, 1'b0, 1'b0);
		cur_player = 1'b1;	// miss hands over
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
		send_pick(5'd16);
		send_pick(5'd16);	// same card twice, dropped
		expect_no_result(2);
		send_pick(5'd0);
		take_result(r);
		check_turn_result(r, 1'b1, 5'd16, 5'd0, 1'b1, 1'b0);
		score1++;
		cleared[1] = 1'b1;
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
	endtask

	task automatic test_backpressure();
		turn_result_t held;
		logic [31:0] extra;
		int stall;
		int waited;
		@(posedge clock);
		result_ready <= 1'b0;
		send_pick(5'd15);
		send_pick(5'd4);
		wait_valid(WAIT_LIMIT, held, waited);
		draw_bits(3, extra);
		stall = 2 + int'(extra);	// 2..9 stalled cycles
		repeat (stall)
		begin
			@(negedge clock);
			check_value("result", 32'(result), 32'(held));	// payload frozen
			check_value("result_valid", 32'(result_valid), 32'd1);
			check_value("pick_ready", 32'(pick_ready), 32'd0);
			check_scores(score0, score1);
		end
		@(posedge clock);
		result_ready <= 1'b1;
		@(posedge clock);	// handshake edge
		@(negedge clock);
		check_turn_result(held, 1'b1, 5'd15, 5'd4, 1'b1, 1'b0);
		score1++;
		cleared[2] = 1'b1;
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
		check_timer_full();
	endtask

	task automatic test_timeout();
		turn_result_t r;
		int waited;
		wait_valid((TURN_SECONDS + 1) * TICKS_PER_SECOND + 2, r, waited);
		if (waited < TURN_SECONDS * TICKS_PER_SECOND)
		begin
			failures++;
			$display("timeout result after only %0d cycles at %0t", waited, $time);
		end
		check_turn_result(r, cur_player, 5'd0, 5'd0, 1'b0, 1'b1);	// no card chosen
		@(posedge clock);	// handshake edge
		@(negedge clock);
		cur_player = ~cur_player;
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
		check_timer_full();
	endtask

	task automatic test_game_over();
		turn_result_t r;
		for (int k = 0; k < 9; k++)
		begin
			if (!cleared[k[3:0]])
			begin
				send_pick(PAIR_A[k]);
				send_pick(PAIR_B[k]);
				take_result(r);
				check_turn_result(r, cur_player, PAIR_A[k], PAIR_B[k], 1'b1, 1'b0);
				if (cur_player)
					score1++;
				else
					score0++;
				cleared[k[3:0]] = 1'b1;
				check_scores(score0, score1);
			end
		end
		check_value("game_over", 32'(game_over), 32'd1);
		check_value("pick_ready", 32'(pick_ready), 32'd0);
		check_value("player", 32'(player), 32'(cur_player));
		check_scores(score0, score1);
	endtask

	initial
	begin
		clock = 1'b0;
		reset_n = 1'b0;
		pick = '0;
		pick_valid = 1'b0;
		result_ready = 1'b1;	// sink takes results unless stalled
		mismatches = 0;
		failures = 0;
		lfsr_state = 32'hd61d;
		score0 = 0;
		score1 = 0;
		cur_player = 1'b0;
		cleared = '0;
		repeat (4) @(posedge clock);
		reset_n <= 1'b1;
		test_reset();
		test_match();
		test_miss();
		test_backpressure();
		test_timeout();
		test_game_over();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- memory_game.sv
// memory game top: board, turn FSM, scores, countdown and seven-segment display
`timescale 1ns/1ps

module memory_game #(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int TURN_SECONDS = 15
) (
	input logic clock,
	input logic reset_n,
	input game_pkg::card_pick_t pick,
	input logic pick_valid,
	output logic pick_ready,
	output game_pkg::turn_result_t result,
	output logic result_valid,
	input logic result_ready,
	output game_pkg::player_t player,
	output logic game_over,
	output display_pkg::seg_digits_t digits
);
	import game_pkg::*;
	import display_pkg::*;

	card_idx_t candidate;	// card offered for the free check
	card_idx_t card_a;	// held pair for the match check
	card_idx_t card_b;
	logic card_free;
	logic pair_match;
	logic commit_match;	// matched result taken
	logic result_fire;	// any result taken
	logic time_up;
	logic turn_open;
	seconds_t seconds;
	score_t score_p0;
	score_t score_p1;

	assign result_fire = result_valid && result_ready;	// turn commits here

	board_state i_board (
		.clock, .reset_n, .candidate, .card_a, .card_b,
		.commit_match, .card_free, .pair_match, .game_over
	);

	turn_control i_turn (
		.clock, .reset_n, .pick, .pick_valid, .pick_ready,
		.result, .result_valid, .result_ready,
		.candidate, .card_a, .card_b, .commit_match,
		.card_free, .pair_match, .game_over, .player,
		.time_up, .turn_open
	);

	score_keeper i_score (
		.clock, .reset_n, .result, .result_fire,
		.player, .score_p0, .score_p1
	);

	turn_timer #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.TURN_SECONDS(TURN_SECONDS)
	) i_timer (
		.clock, .reset_n, .turn_open,
		.reload(result_fire),	// every committed turn restarts the clock
		.seconds, .time_up
	);

	score_display #(
		.TURN_SECONDS(TURN_SECONDS)
	) i_display (
		.score_p0, .score_p1, .seconds, .digits
	);

endmodule

//--- score_display.sv
// display encoder: splits the countdown into decimal digits and drives four active-low digits
`timescale 1ns/1ps

module score_display #(
	parameter int TURN_SECONDS = 15
) (
	input game_pkg::score_t score_p0,
	input game_pkg::score_t score_p1,
	input display_pkg::seconds_t seconds,
	output display_pkg::seg_digits_t digits
);
	import display_pkg::*;

	localparam bit SHOW_TENS = (TURN_SECONDS >= 10);	// short turns never need a tens digit

	digit_t tens;
	digit_t units;

	// pattern for one decimal digit, dark above 9
	function automatic seg_t encode(input digit_t value);
		seg_t pattern;
		pattern = SEG_BLANK;
		if (value < 4'd10)
			pattern = SEG_DIGIT[value];
		return pattern;
	endfunction

	// decimal split of the countdown
	always_comb
	begin
		tens = digit_t'(seconds / 6'd10);
		units = digit_t'(seconds % 6'd10);
	end

	always_comb
	begin
		digits.score_p0 = encode(score_p0);
		digits.score_p1 = encode(score_p1);
		digits.timer_tens = SHOW_TENS ? encode(tens) : SEG_BLANK;	// blank leading digit
		digits.timer_units = encode(units);
	end

endmodule

//--- turn_timer.sv
// turn timer: seconds prescaler and per-turn countdown with a one-cycle expiry pulse
`timescale 1ns/1ps

module turn_timer #(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int TURN_SECONDS = 15
) (
	input logic clock,
	input logic reset_n,
	input logic turn_open,
	input logic reload,
	output display_pkg::seconds_t seconds,
	output logic time_up
);
	import display_pkg::*;

	localparam int PRE_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_SECOND - 1);	// last cycle of a second
	localparam seconds_t START = seconds_t'(TURN_SECONDS);	// value after reload

	logic [PRE_W-1:0] prescale;	// cycles into the current second
	logic tick;	// one-second strobe

	assign tick = turn_open && (prescale == PRE_LAST);

	// prescaler runs only during an open turn, restarts with each turn
	always_ff @(posedge clock)
	begin
		if (!reset_n)
			prescale <= '0;
		else if (reload)
			prescale <= '0;
		else if (turn_open)
			prescale <= tick ? '0 : prescale + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			seconds <= START;
			time_up <= 1'b0;
		end
		else if (reload)
		begin
			seconds <= START;	// fresh turn
			time_up <= 1'b0;
		end
		else
		begin
			time_up <= tick && (seconds == seconds_t'(1));	// last second runs out
			if (tick && (seconds != '0))
				seconds <= seconds - 1'b1;	// holds at zero
		end
	end

	// countdown never climbs above the turn length
	assert property (@(posedge clock) disable iff (!reset_n) seconds <= START)
	else
		$error("countdown above turn length");

endmodule

//--- score_keeper.sv
// score keeper: current player and the two per-player score digits, updated on each committed turn
`timescale 1ns/1ps

module score_keeper (
	input logic clock,
	input logic reset_n,
	input game_pkg::turn_result_t result,
	input logic result_fire,
	output game_pkg::player_t player,
	output game_pkg::score_t score_p0,
	output game_pkg::score_t score_p1
);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			player <= 1'b0;	// player 0 opens
			score_p0 <= '0;
			score_p1 <= '0;
		end
		else if (result_fire)
		begin
			if (result.matched)
			begin
				// scorer keeps the turn
				if (result.player == 1'b0)
					score_p0 <= score_p0 + 1'b1;
				else
					score_p1 <= score_p1 + 1'b1;
			end
			else
			begin
				player <= ~result.player;	// miss or timeout passes the turn
			end
		end
	end

endmodule

//--- turn_control.sv
// turn FSM: takes card picks, holds the chosen cards and issues the registered turn result
`timescale 1ns/1ps

module turn_control (
	input logic clock,
	input logic reset_n,
	input game_pkg::card_pick_t pick,
	input logic pick_valid,
	output logic pick_ready,
	output game_pkg::turn_result_t result,
	output logic result_valid,
	input logic result_ready,
	output game_pkg::card_idx_t candidate,
	output game_pkg::card_idx_t card_a,
	output game_pkg::card_idx_t card_b,
	output logic commit_match,
	input logic card_free,
	input logic pair_match,
	input logic game_over,
	input game_pkg::player_t player,
	input logic time_up,
	output logic turn_open
);
	import game_pkg::*;

	typedef enum logic [1:0] {
		choose_first,	// waiting for first card
		choose_second,	// first card held, waiting for second
		report_turn,	// result offered downstream
		game_done	// board empty, no more picks
	} state_t;

	state_t state;
	card_idx_t first_q;	// first card of the turn
	turn_result_t result_q;	// payload, held under back-pressure
	logic choosing;
	logic pick_fire;	// pick handshake
	logic pick_legal;	// card still free and not the first card again
	logic result_fire;	// result handshake

	assign choosing = (state == choose_first) || (state == choose_second);
	assign pick_ready = choosing && !game_over && !time_up;	// timeout wins over a pick
	assign pick_fire = pick_valid && pick_ready;
	assign candidate = pick.card;	// board checks the offered card
	assign pick_legal = card_free && !((state == choose_second) && (pick.card == first_q));

	assign result = result_q;
	assign result_valid = (state == report_turn);
	assign result_fire = result_valid && result_ready;
	assign commit_match = result_fire && result_q.matched;	// board drops the pair
	assign turn_open = choosing && !game_over;	// timer runs only here

	// pair check sees the incoming card while choosing the second
	assign card_a = first_q;
	assign card_b = (state == choose_second) ? pick.card : result_q.card_b;

	always_ff @(posedge clock)
	begin
		if (!reset_n)
			state <= choose_first;
		else
		begin
			case (state)
				choose_first, choose_second:
					if (game_over)
						state <= game_done;
					else if (time_up)
						state <= report_turn;	// timeout result next cycle
					else if (pick_fire && pick_legal)
						state <= (state == choose_first) ? choose_second : report_turn;
				report_turn:
					if (result_ready)
						state <= choose_first;	// next turn, same or other player
				default:
					state <= game_done;	// stays here until reset
			endcase
		end
	end

	// chosen cards and result payload
	always_ff @(posedge clock)
	begin
		if (choosing && time_up)
		begin
			result_q.player <= player;
			result_q.card_a <= (state == choose_second) ? first_q : '0;
			result_q.card_b <= '0;	// second card never chosen
			result_q.matched <= 1'b0;
			result_q.timed_out <= 1'b1;
		end
		else if (pick_fire && pick_legal)
		begin
			if (state == choose_first)
				first_q <= pick.card;
			else
			begin
				result_q.player <= player;
				result_q.card_a <= first_q;
				result_q.card_b <= pick.card;
				result_q.matched <= pair_match;	// board answer for the held pair
				result_q.timed_out <= 1'b0;
			end
		end
	end

	// stalled result keeps its payload until taken
	assert property (@(posedge clock) disable iff (!reset_n)
		(result_valid && !result_ready) |=> (result_valid && $stable(result)))
	else
		$error("result changed under back-pressure");

endmodule

//--- board_state.sv
// board state: removed-card mask, free-card and pair checks, cleared-pair count and game over
`timescale 1ns/1ps

module board_state (
	input logic clock,
	input logic reset_n,
	input game_pkg::card_idx_t candidate,
	input game_pkg::card_idx_t card_a,
	input game_pkg::card_idx_t card_b,
	input logic commit_match,
	output logic card_free,
	output logic pair_match,
	output logic game_over
);
	import game_pkg::*;

	card_mask_t removed;	// cards already taken off the board
	logic [3:0] pairs_done;	// pairs cleared so far
	card_mask_t cand_bit;	// one-hot of the candidate
	card_mask_t pair_bits;	// one-hot of both held cards
	logic cand_on_board;	// candidate index inside the board
	logic a_on_board;

	assign cand_bit = card_mask_t'(1) << candidate;
	assign pair_bits = (card_mask_t'(1) << card_a) | (card_mask_t'(1) << card_b);
	assign cand_on_board = candidate < card_idx_t'(NUM_CARDS);
	assign a_on_board = card_a < card_idx_t'(NUM_CARDS);

	// out-of-range index counts as not free
	assign card_free = cand_on_board && ((removed & cand_bit) == '0);

	// table lookup from the first card
	always_comb
	begin
		pair_match = 1'b0;
		if (a_on_board)
			pair_match = (pair_partner[card_a] == card_b);
	end

	assign game_over = (pairs_done == 4'(NUM_PAIRS));	// every pair gone

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			removed <= '0;	// full board
			pairs_done <= '0;
		end
		else if (commit_match)
		begin
			removed <= removed | pair_bits;	// both cards leave
			pairs_done <= pairs_done + 1'b1;
		end
	end

	// a committed match only ever takes cards still on the board
	assert property (@(posedge clock) disable iff (!reset_n)
		commit_match |-> ((removed & pair_bits) == '0))
	else
		$error("commit of a card already removed");

endmodule

//--- display_pkg.sv
// seven-segment display types, decimal digit and countdown types, active-low digit patterns
package display_pkg;

	typedef logic [6:0] seg_t;	// segments g..a, low lights the segment
	typedef logic [3:0] digit_t;	// decimal digit 0..9
	typedef logic [5:0] seconds_t;	// countdown value

	typedef struct packed {
		seg_t score_p0;	// player 0 score
		seg_t score_p1;	// player 1 score
		seg_t timer_tens;
		seg_t timer_units;
	} seg_digits_t;

	localparam seg_t SEG_BLANK = 7'b1111111;	// all segments dark

	// patterns for 0..9
	localparam seg_t SEG_DIGIT [10] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0011000
	};

endpackage

//--- game_pkg.sv
// memory game rules: board size, card and score types, fixed pair table, turn result
package game_pkg;

	localparam int NUM_CARDS = 18;	// cards dealt face down
	localparam int NUM_PAIRS = 9;	// pairs to clear before game over

	typedef logic [4:0] card_idx_t;	// card number 0..17
	typedef logic [NUM_CARDS-1:0] card_mask_t;	// one bit per card, set once removed
	typedef logic player_t;	// player 0 or 1
	typedef logic [3:0] score_t;	// one decimal digit per player

	// partner of each card, indexed by card number
	localparam card_idx_t pair_partner [NUM_CARDS] = '{
		5'd16,	// 0
		5'd6,	// 1
		5'd13,	// 2
		5'd14,	// 3
		5'd15,	// 4
		5'd8,	// 5
		5'd1,	// 6
		5'd9,	// 7
		5'd5,	// 8
		5'd7,	// 9
		5'd17,	// 10
		5'd12,	// 11
		5'd11,	// 12
		5'd2,	// 13
		5'd3,	// 14
		5'd4,	// 15
		5'd0,	// 16
		5'd10	// 17
	};

	typedef struct packed {
		card_idx_t card;	// card the player turns over
	} card_pick_t;

	typedef struct packed {
		player_t player;	// who played the turn
		card_idx_t card_a;	// first card, zero if none
		card_idx_t card_b;	// second card, zero if none
		logic matched;	// pair found, cards leave the board
		logic timed_out;	// turn ended by the countdown
	} turn_result_t;

endpackage
